// ==== logic/packing_pkg.sv ====
`default_nettype none

package packing_pkg;

    // --------------------------------------------------
    // Board and gift list sizes
    // --------------------------------------------------
    localparam int BOARD_ROWS    = 16;   // Also the tallest region
    localparam int ROW_BITS      = 16;   // Also the widest region
    localparam int ROW_ADDR_BITS = 4;
    localparam int NUM_SHAPES    = 6;
    localparam int SHAPE_ID_BITS = 3;
    localparam int MAX_GIFTS     = 12;
    localparam int GIFT_IDX_BITS = 4;

    // --------------------------------------------------
    // Shape patterns
    // --------------------------------------------------
    localparam int SHAPE_SIZE    = 3;    // Side of the pattern box
    localparam int NUM_ROTATIONS = 4;
    localparam int ROT_BITS      = 2;

    // Word is {row2, row1, row0}, bit c of a row is column c
    localparam logic [SHAPE_SIZE*SHAPE_SIZE-1:0] BASE_SHAPES [NUM_SHAPES] = '{
        9'b111_110_110,
        9'b111_110_011,
        9'b011_111_110,
        9'b110_111_110,
        9'b111_001_111,
        9'b111_010_111
    };

    // Row view for picking one board row, cell view for rotating
    // Cell at row r, column c sits at cells[SHAPE_SIZE*r + c]
    typedef union packed {
        logic [SHAPE_SIZE-1:0][SHAPE_SIZE-1:0] rows;
        logic [SHAPE_SIZE*SHAPE_SIZE-1:0]      cells;
    } shape_cells_u;

endpackage

`default_nettype wire

// ==== logic/request_reader.sv ====
`default_nettype none

module request_reader (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    s_tvalid,
    output logic                                   s_tready,
    input  wire  [31:0]                            s_tdata,
    input  wire                                    busy,
    output logic [7:0]                             region_w,
    output logic [7:0]                             region_h,
    output logic                                   list_clear,
    output logic                                   gift_wr,
    output logic [packing_pkg::SHAPE_ID_BITS-1:0]  gift_wr_id,
    output logic                                   start
);

    typedef enum logic [1:0] {
        S_HEADER,
        S_COUNTS,
        S_EXPAND
    } state_e;

    state_e                                state;
    logic [packing_pkg::SHAPE_ID_BITS-1:0] shape_idx;   // Count word, then expand cursor
    logic [7:0]                            counts [packing_pkg::NUM_SHAPES];
    logic [10:0]                           gift_total;  // Sum of all six counts

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_HEADER;
            s_tready   <= 1'b0;
            region_w   <= '0;
            region_h   <= '0;
            list_clear <= 1'b0;
            gift_wr    <= 1'b0;
            gift_wr_id <= '0;
            start      <= 1'b0;
            shape_idx  <= '0;
            gift_total <= '0;
        end else begin
            list_clear <= 1'b0;
            gift_wr    <= 1'b0;
            start      <= 1'b0;
            case (state)
                S_HEADER: begin
                    // Hold off while the previous request is still solving
                    s_tready <= !busy && !start;
                    if (s_tvalid && s_tready) begin
                        region_w   <= s_tdata[15:8];
                        region_h   <= s_tdata[7:0];
                        list_clear <= 1'b1;
                        shape_idx  <= '0;
                        gift_total <= '0;
                        s_tready   <= 1'b1;
                        state      <= S_COUNTS;
                    end
                end
                S_COUNTS: begin
                    if (s_tvalid && s_tready) begin
                        counts[shape_idx] <= s_tdata[7:0];
                        gift_total        <= gift_total + s_tdata[7:0];
                        if (shape_idx == packing_pkg::NUM_SHAPES - 1) begin
                            s_tready  <= 1'b0;
                            shape_idx <= '0;
                            state     <= S_EXPAND;
                        end else begin
                            shape_idx <= shape_idx + 1'b1;
                        end
                    end
                end
                S_EXPAND: begin
                    // One append per cycle, one extra cycle to leave each shape
                    if (counts[shape_idx] != 8'd0) begin
                        gift_wr           <= 1'b1;
                        gift_wr_id        <= shape_idx;
                        counts[shape_idx] <= counts[shape_idx] - 1'b1;
                    end else if (shape_idx == packing_pkg::NUM_SHAPES - 1) begin
                        start <= 1'b1;
                        state <= S_HEADER;
                    end else begin
                        shape_idx <= shape_idx + 1'b1;
                    end
                end
                default: state <= S_HEADER;
            endcase
        end
    end

    // Request must fit the gift list and the 16x16 board
    a_request_fits: assert property (@(posedge clk) disable iff (!rst_n)
        state == S_EXPAND |-> gift_total <= packing_pkg::MAX_GIFTS
            && region_w <= packing_pkg::ROW_BITS && region_h <= packing_pkg::BOARD_ROWS);

endmodule

`default_nettype wire

// ==== logic/gift_list.sv ====
`default_nettype none

module gift_list (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    list_clear,
    input  wire                                    gift_wr,
    input  wire  [packing_pkg::SHAPE_ID_BITS-1:0]  gift_wr_id,
    input  wire  [packing_pkg::GIFT_IDX_BITS-1:0]  gift_rd_idx,
    output logic [packing_pkg::SHAPE_ID_BITS-1:0]  gift_rd_id,
    output logic [packing_pkg::GIFT_IDX_BITS-1:0]  gift_count
);

    logic [packing_pkg::SHAPE_ID_BITS-1:0] ids [packing_pkg::MAX_GIFTS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gift_count <= '0;
        end else if (list_clear) begin
            gift_count <= '0;
        end else if (gift_wr) begin
            gift_count <= gift_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (gift_wr && !list_clear)
            ids[gift_count] <= gift_wr_id;    // Append at the tail
    end

    assign gift_rd_id = ids[gift_rd_idx];

    // Reader never overfills the list
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        gift_wr |-> gift_count < packing_pkg::MAX_GIFTS);

    // Solver only walks stored entries
    a_read_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        gift_count != '0 |-> gift_rd_idx < gift_count);

endmodule

`default_nettype wire

// ==== logic/board_ram.sv ====
`default_nettype none

module board_ram (
    input  wire                                    clk,
    input  wire                                    wr_en,
    input  wire  [packing_pkg::ROW_ADDR_BITS-1:0]  addr,
    input  wire  [packing_pkg::ROW_BITS-1:0]       wr_row,
    output logic [packing_pkg::ROW_BITS-1:0]       rd_row
);

    // One occupancy bit per cell
    logic [packing_pkg::ROW_BITS-1:0] rows [packing_pkg::BOARD_ROWS];

    always_ff @(posedge clk) begin
        if (wr_en)
            rows[addr] <= wr_row;
        rd_row <= rows[addr];   // Old data on a same-address write
    end

endmodule

`default_nettype wire

// ==== logic/shape_rotator.sv ====
`default_nettype none

module shape_rotator (
    input  wire  [packing_pkg::SHAPE_ID_BITS-1:0] shape_id,
    input  wire  [packing_pkg::ROT_BITS-1:0]      rotation,
    input  wire  [7:0]                            pos_x,
    input  wire  [1:0]                            rel_row,
    output logic [packing_pkg::ROW_BITS-1:0]      row_mask,
    output logic                                  spill
);

    localparam int SZ = packing_pkg::SHAPE_SIZE;
    localparam int WIDE_BITS = packing_pkg::ROW_BITS + SZ - 1;

    packing_pkg::shape_cells_u turned;
    packing_pkg::shape_cells_u step;
    logic [SZ-1:0]             sel_row;
    logic [WIDE_BITS-1:0]      wide;

    always_comb begin
        turned.cells = packing_pkg::BASE_SHAPES[shape_id];
        step         = turned;
        // Quarter turns, (r, c) moves to (c, SZ-1-r)
        for (int q = 0; q < packing_pkg::NUM_ROTATIONS - 1; q++) begin
            if (q < rotation) begin
                for (int r = 0; r < SZ; r++) begin
                    for (int c = 0; c < SZ; c++)
                        step.cells[SZ*c + SZ-1-r] = turned.cells[SZ*r + c];
                end
                turned = step;
            end
        end
    end

    assign sel_row = (rel_row < SZ) ? turned.rows[rel_row] : '0;
    assign wide    = {{(packing_pkg::ROW_BITS-1){1'b0}}, sel_row} << pos_x;

    assign row_mask = wide[packing_pkg::ROW_BITS-1:0];
    // Cells pushed past the right edge of the board
    assign spill = (|wide[WIDE_BITS-1:packing_pkg::ROW_BITS])
                || (pos_x >= packing_pkg::ROW_BITS && sel_row != '0);

endmodule

`default_nettype wire

// ==== logic/placement_solver.sv ====
`default_nettype none

module placement_solver (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    start,
    input  wire  [7:0]                             region_w,
    input  wire  [7:0]                             region_h,
    input  wire  [packing_pkg::SHAPE_ID_BITS-1:0]  gift_rd_id,
    input  wire  [packing_pkg::GIFT_IDX_BITS-1:0]  gift_count,
    input  wire                                    m_tready,
    output logic [packing_pkg::GIFT_IDX_BITS-1:0]  gift_rd_idx,
    output logic                                   busy,
    output logic                                   m_tvalid,
    output logic                                   m_tlast,
    output logic [31:0]                            m_tdata
);

    localparam int RB = packing_pkg::ROW_BITS;

    typedef enum logic [3:0] {
        S_IDLE, S_CLEAR, S_BEGIN,
        S_CHK_ADDR, S_CHK_WAIT, S_CHK_VERIFY, S_CHK_WRITE,
        S_NEXT, S_UNDO_ADDR, S_UNDO_WAIT, S_UNDO_WRITE,
        S_OUTPUT
    } state_e;

    state_e                                state;
    logic [packing_pkg::GIFT_IDX_BITS-1:0] gift_ptr;
    logic [7:0]                            stack_x   [packing_pkg::MAX_GIFTS];
    logic [7:0]                            stack_y   [packing_pkg::MAX_GIFTS];
    logic [packing_pkg::ROT_BITS-1:0]      stack_rot [packing_pkg::MAX_GIFTS];
    logic [RB-1:0]                         merged    [packing_pkg::SHAPE_SIZE];
    logic [1:0]                            row_iter;
    logic [packing_pkg::ROW_ADDR_BITS-1:0] clear_row, ram_addr;
    logic                                  ram_wen, spill, row_fail;
    logic [RB-1:0]                         ram_wdata, ram_rdata, row_mask, in_w_mask;
    logic [RB:0]                           w_lim;
    logic [7:0]                            abs_row;

    board_ram i_board_ram (
        .clk    (clk),
        .wr_en  (ram_wen),
        .addr   (ram_addr),
        .wr_row (ram_wdata),
        .rd_row (ram_rdata)
    );

    shape_rotator i_shape_rotator (
        .shape_id (gift_rd_id),
        .rotation (stack_rot[gift_ptr]),
        .pos_x    (stack_x[gift_ptr]),
        .rel_row  (row_iter),
        .row_mask (row_mask),
        .spill    (spill)
    );

    // --------------------------------------------------
    // Row check against board and region
    // --------------------------------------------------
    assign abs_row   = stack_y[gift_ptr] + row_iter;
    assign w_lim     = {{RB{1'b0}}, 1'b1} << region_w;
    assign in_w_mask = w_lim[RB-1:0] - 1'b1;   // All ones for a full-width region
    assign row_fail  = spill || (row_mask & ~in_w_mask) != '0
                    || (row_mask & ram_rdata) != '0
                    || (abs_row >= region_h && row_mask != '0);

    assign gift_rd_idx = gift_ptr;
    assign m_tlast     = m_tvalid;   // Single-word result

    // --------------------------------------------------
    // Search FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            busy      <= 1'b0;
            m_tvalid  <= 1'b0;
            gift_ptr  <= '0;
            row_iter  <= '0;
            clear_row <= '0;
            ram_addr  <= '0;
            ram_wen   <= 1'b0;
        end else begin
            ram_wen <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        busy      <= 1'b1;
                        clear_row <= '0;
                        state     <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    ram_addr  <= clear_row;
                    ram_wdata <= '0;
                    ram_wen   <= 1'b1;
                    clear_row <= clear_row + 1'b1;
                    if (clear_row == packing_pkg::BOARD_ROWS - 1)
                        state <= S_BEGIN;
                end
                S_BEGIN: begin
                    if (gift_count == '0) begin
                        m_tdata <= 32'd1;   // Nothing to place
                        state   <= S_OUTPUT;
                    end else begin
                        gift_ptr     <= '0;
                        stack_x[0]   <= '0;
                        stack_y[0]   <= '0;
                        stack_rot[0] <= '0;
                        row_iter     <= '0;
                        state        <= S_CHK_ADDR;
                    end
                end
                S_CHK_ADDR: begin
                    ram_addr <= abs_row[packing_pkg::ROW_ADDR_BITS-1:0];
                    state    <= S_CHK_WAIT;
                end
                S_CHK_WAIT: state <= S_CHK_VERIFY;
                S_CHK_VERIFY: begin
                    if (row_fail) begin
                        state <= S_NEXT;
                    end else begin
                        merged[row_iter] <= ram_rdata | row_mask;
                        if (row_iter == packing_pkg::SHAPE_SIZE - 1) begin
                            row_iter <= '0;
                            state    <= S_CHK_WRITE;
                        end else begin
                            row_iter <= row_iter + 1'b1;
                            state    <= S_CHK_ADDR;
                        end
                    end
                end
                S_CHK_WRITE: begin
                    // All rows passed, commit one row per cycle
                    ram_addr  <= abs_row[packing_pkg::ROW_ADDR_BITS-1:0];
                    ram_wdata <= merged[row_iter];
                    ram_wen   <= abs_row < region_h;
                    if (row_iter != packing_pkg::SHAPE_SIZE - 1) begin
                        row_iter <= row_iter + 1'b1;
                    end else if (gift_ptr == gift_count - 1'b1) begin
                        m_tdata  <= 32'd1;
                        gift_ptr <= '0;
                        state    <= S_OUTPUT;
                    end else begin
                        gift_ptr                   <= gift_ptr + 1'b1;
                        stack_x[gift_ptr + 1'b1]   <= '0;
                        stack_y[gift_ptr + 1'b1]   <= '0;
                        stack_rot[gift_ptr + 1'b1] <= '0;
                        row_iter                   <= '0;
                        state                      <= S_CHK_ADDR;
                    end
                end
                S_NEXT: begin
                    row_iter <= '0;
                    state    <= S_CHK_ADDR;
                    // Orientation first, then x, then y
                    if (stack_rot[gift_ptr] < packing_pkg::NUM_ROTATIONS - 1) begin
                        stack_rot[gift_ptr] <= stack_rot[gift_ptr] + 1'b1;
                    end else if (stack_x[gift_ptr] + 8'd1 < region_w) begin
                        stack_rot[gift_ptr] <= '0;
                        stack_x[gift_ptr]   <= stack_x[gift_ptr] + 1'b1;
                    end else if (stack_y[gift_ptr] + 8'd1 < region_h) begin
                        stack_rot[gift_ptr] <= '0;
                        stack_x[gift_ptr]   <= '0;
                        stack_y[gift_ptr]   <= stack_y[gift_ptr] + 1'b1;
                    end else if (gift_ptr == '0) begin
                        m_tdata <= 32'd0;   // Search space exhausted
                        state   <= S_OUTPUT;
                    end else begin
                        gift_ptr <= gift_ptr - 1'b1;   // Pop, then lift that gift
                        state    <= S_UNDO_ADDR;
                    end
                end
                S_UNDO_ADDR: begin
                    ram_addr <= abs_row[packing_pkg::ROW_ADDR_BITS-1:0];
                    state    <= S_UNDO_WAIT;
                end
                S_UNDO_WAIT: state <= S_UNDO_WRITE;
                S_UNDO_WRITE: begin
                    ram_wdata <= ram_rdata & ~row_mask;
                    ram_wen   <= abs_row < region_h;
                    if (row_iter == packing_pkg::SHAPE_SIZE - 1) begin
                        row_iter <= '0;
                        state    <= S_NEXT;
                    end else begin
                        row_iter <= row_iter + 1'b1;
                        state    <= S_UNDO_ADDR;
                    end
                end
                S_OUTPUT: begin
                    m_tvalid <= 1'b1;
                    if (m_tvalid && m_tready) begin
                        m_tvalid <= 1'b0;
                        busy     <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Result word holds under back-pressure
    a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

endmodule

`default_nettype wire

// ==== logic/packing_top.sv ====
`default_nettype none

module packing_top (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         s_tvalid,
    output logic        s_tready,
    input  wire  [31:0] s_tdata,
    output logic        m_tvalid,
    input  wire         m_tready,
    output logic        m_tlast,
    output logic [31:0] m_tdata
);

    logic [7:0]                            region_w, region_h;
    logic                                  busy, start, list_clear, gift_wr;
    logic [packing_pkg::SHAPE_ID_BITS-1:0] gift_wr_id, gift_rd_id;
    logic [packing_pkg::GIFT_IDX_BITS-1:0] gift_rd_idx, gift_count;

    // --------------------------------------------------
    // Request in, gift list, search and result out
    // --------------------------------------------------
    request_reader i_request_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_tdata    (s_tdata),
        .busy       (busy),
        .region_w   (region_w),
        .region_h   (region_h),
        .list_clear (list_clear),
        .gift_wr    (gift_wr),
        .gift_wr_id (gift_wr_id),
        .start      (start)
    );

    gift_list i_gift_list (
        .clk         (clk),
        .rst_n       (rst_n),
        .list_clear  (list_clear),
        .gift_wr     (gift_wr),
        .gift_wr_id  (gift_wr_id),
        .gift_rd_idx (gift_rd_idx),
        .gift_rd_id  (gift_rd_id),
        .gift_count  (gift_count)
    );

    placement_solver i_placement_solver (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .region_w    (region_w),
        .region_h    (region_h),
        .gift_rd_id  (gift_rd_id),
        .gift_count  (gift_count),
        .m_tready    (m_tready),
        .gift_rd_idx (gift_rd_idx),
        .busy        (busy),
        .m_tvalid    (m_tvalid),
        .m_tlast     (m_tlast),
        .m_tdata     (m_tdata)
    );

endmodule

`default_nettype wire

// ==== testbench/packing_tb.sv ====
`default_nettype none

module packing_tb;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        s_tvalid;
    logic        s_tready;
    logic [31:0] s_tdata;
    logic        m_tvalid;
    logic        m_tready = 1'b0;
    logic        m_tlast;
    logic [31:0] m_tdata;

    logic        s_last;              // Marks the sixth count word
    logic        pending = 1'b0;      // Request sent, result not yet taken
    logic        heavy_stall = 1'b0;  // Mostly low m_tready
    logic [31:0] exp_data = '0;
    logic [15:0] lfsr = 16'd19;
    logic [15:0] gap_lfsr = 16'd19;   // Separate stream for m_tready gaps
    int unsigned cycles = 0;
    int unsigned cycle_limit = 200;   // Grows with every request
    int unsigned requests_sent = 0;
    int unsigned results_seen = 0;

    packing_top i_packing_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tdata  (m_tdata)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // Random source
    // --------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic int pick_shape();
        return take_bits(3) % 6;
    endfunction

    always @(negedge clk) begin
        gap_lfsr = lfsr_step(gap_lfsr);
        gap_lfsr = lfsr_step(gap_lfsr);
        if (heavy_stall)
            m_tready = (gap_lfsr[1:0] == 2'b00);
        else
            m_tready = (gap_lfsr[1:0] != 2'b00);
    end

    // --------------------------------------------------
    // Bookkeeping and timeout
    // --------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (s_tvalid && s_tready && s_last)
            pending <= 1'b1;
        else if (m_tvalid && m_tready)
            pending <= 1'b0;
        if (m_tvalid && m_tready)
            results_seen <= results_seen + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run passed its limit of %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && m_tready |-> m_tdata == exp_data)
    else begin
        $display("ERROR at %0t: m_tdata expected %0h actual %0h",
                 $time, exp_data, $sampled(m_tdata));
        $display("TESTS FAILED");
        $fatal(1);
    end

    a_output_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
    else begin
        $display("Output word dropped or changed at %0t while m_tready was low", $time);
        $display("TESTS FAILED");
        $fatal(1);
    end

    a_last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        m_tlast == m_tvalid)
    else begin
        $display("ERROR at %0t: m_tlast expected %b actual %b",
                 $time, $sampled(m_tvalid), $sampled(m_tlast));
        $display("TESTS FAILED");
        $fatal(1);
    end

    a_input_held_off: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> !s_tready)
    else begin
        $display("Input stream was ready at %0t before the result was taken", $time);
        $display("TESTS FAILED");
        $fatal(1);
    end

    a_no_spurious_result: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid |-> pending)
    else begin
        $display("Result word at %0t without a complete request", $time);
        $display("TESTS FAILED");
        $fatal(1);
    end

    // --------------------------------------------------
    // Request driver
    // --------------------------------------------------
    task automatic send_word(input logic [31:0] data, input logic last_word);
        s_tvalid = 1'b1;
        s_tdata  = data;
        s_last   = last_word;
        while (!s_tready)
            @(negedge clk);
        @(negedge clk);   // Handshake done at the rising edge in between
        s_tvalid = 1'b0;
        s_last   = 1'b0;
    endtask

    // Counts indexed by shape id
    task automatic send_request(input logic [7:0] w, input logic [7:0] h,
                                input logic [5:0][7:0] counts, input logic exp_bit);
        int unsigned gifts;
        int unsigned tries;
        gifts = 0;
        for (int i = 0; i < 6; i++)
            gifts += counts[i];
        tries = 4 * w * h;                 // Positions for one gift
        if (gifts >= 2)
            tries = tries * tries;
        cycle_limit += 200 + 24 * tries;
        send_word({16'd0, w, h}, 1'b0);
        exp_data = {31'd0, exp_bit};       // Previous result already taken
        for (int i = 0; i < 6; i++)
            send_word({24'd0, counts[i]}, i == 5);
        requests_sent++;
    endtask

    initial begin
        logic [5:0][7:0] counts;
        logic [7:0]      w;
        logic [7:0]      h;
        int              s;
        rst_n    = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_last   = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Nothing to place
        for (int i = 0; i < 2; i++) begin
            counts = '0;
            w      = 8'(take_bits(4) + 1);
            h      = 8'(take_bits(4) + 1);
            send_request(w, h, counts, 1'b1);
        end

        // Every shape spans a 3x3 box
        for (int i = 0; i < 3; i++) begin
            counts              = '0;
            counts[pick_shape()] = 8'd1;
            w = (i == 0) ? 8'(take_bits(1) + 1) : 8'(take_bits(4) % 14 + 3);
            h = (i == 1) ? 8'(take_bits(1) + 1) : 8'(take_bits(4) % 14 + 3);
            if (i == 2) begin
                w = 8'd3;
                h = 8'd3;
            end
            send_request(w, h, counts, i == 2);
        end

        // One 3x3 block per gift with heavy back-pressure
        heavy_stall = 1'b1;
        for (int k = 1; k <= 4; k++) begin
            counts = '0;
            for (int g = 0; g < k; g++) begin
                s         = pick_shape();
                counts[s] = counts[s] + 8'd1;
            end
            send_request(8'(3 * k), 8'd3, counts, 1'b1);
        end
        heavy_stall = 1'b0;

        // Two gifts of 7 cells each overflow a region of at most 12 cells
        for (int r = 0; r < 3; r++) begin
            counts = '0;
            for (int g = 0; g < 2; g++) begin
                s         = pick_shape();
                counts[s] = counts[s] + 8'd1;
            end
            w = (r == 1) ? 8'd4 : 8'd3;
            h = (r == 2) ? 8'd4 : 8'd3;
            send_request(w, h, counts, 1'b0);
        end

        while (pending || m_tvalid)
            @(negedge clk);
        repeat (4) @(negedge clk);
        if (results_seen == requests_sent) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Sent %0d requests but saw %0d results", requests_sent, results_seen);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/packing_pkg.sv
logic/request_reader.sv
logic/gift_list.sv
logic/board_ram.sv
logic/shape_rotator.sv
logic/placement_solver.sv
logic/packing_top.sv
testbench/packing_tb.sv
